// File: sources.f
+incdir+rtl
rtl/dsp_sample_pkg.sv
rtl/dsp_ctrl_pkg.sv
rtl/shot_sequencer.sv
rtl/bb_select.sv
rtl/acc_buf_writer.sv
rtl/dsp_top.sv
tests/dsp_top_sva.sv
tests/dsp_top_tb.sv

// File: Bender.yml
package:
  name: dsp_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dsp_sample_pkg.sv
      - rtl/dsp_ctrl_pkg.sv
      - rtl/shot_sequencer.sv
      - rtl/bb_select.sv
      - rtl/acc_buf_writer.sv
      - rtl/dsp_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/dsp_top_sva.sv
      - tests/dsp_top_tb.sv

// File: tests/dsp_top_tb.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module dsp_top_tb;
	import dsp_sample_pkg::*;
	import dsp_ctrl_pkg::*;

	// three experiments of up to 5 shots plus the bursts, with margin
	localparam int MAX_CYCLES = 4000;

	logic                  dspif;
	logic                  reset;
	logic                  stb_start;
	shot_count_t           nshot;
	logic [`DSP_NPROC-1:0] proc_done;
	logic [`DSP_NPROC-1:0] proc_idle;
	adc_word_t             adc;
	dac_word_t             dac [0:`DSP_NDAC-1];
	bb_sel_t               mixbb1_sel;
	bb_sel_t               mixbb2_sel;
	logic [`DSP_NACC-1:0]  acc_valid;
	acc_data_t             acc_data [0:`DSP_NACC-1];
	logic                  resetacc;
	logic [`DSP_NPROC-1:0] proc_reset;
	shot_count_t           shot_count;
	logic                  last_shot_done;
	logic                  procdone;
	adc_word_t             mixbb1;
	adc_word_t             mixbb2;
	logic [`DSP_NACC-1:0]  we_accbuf;
	acc_addr_t             addr_accbuf [0:`DSP_NACC-1];
	acc_data_t             data_accbuf [0:`DSP_NACC-1];
	logic [`DSP_NACC-1:0]  meas_bit;
	logic [`DSP_NACC-1:0]  meas_valid;
	logic                  stb_start_d;

	int cycles = 0;
	// per-core countdowns of the core model
	int done_wait [`DSP_NPROC];
	int idle_wait [`DSP_NPROC];

	dsp_top dut0 (.*);

	always #50 dspif = ~dspif;

	task automatic abort_run(input string why);
		$display("Testbench failed");
		$fatal(1, "%s", why);
	endtask

	function automatic dac_word_t rand_dac();
		dac_word_t w;
		for (int k = 0; k < `DSP_DAC_W / 32; k++) begin
			w[32*k +: 32] = $urandom;
		end
		return w;
	endfunction

	// core model: done some cycles after release, idle some cycles after reset
	always @(posedge dspif) begin
		#1;
		for (int i = 0; i < `DSP_NPROC; i++) begin
			if (proc_reset[i]) begin
				proc_done[i] = 1'b0;
				done_wait[i] = 1 + $urandom % 8;
				if (idle_wait[i] > 0) begin
					idle_wait[i]--;
				end else begin
					proc_idle[i] = 1'b1;
				end
			end else begin
				proc_idle[i] = 1'b0;
				idle_wait[i] = 1 + $urandom % 4;
				if (done_wait[i] > 0) begin
					done_wait[i]--;
				end else begin
					proc_done[i] = 1'b1;
				end
			end
		end
	end

	// random converter data and select codes 0 to 2
	always @(posedge dspif) begin
		#1;
		adc = {$urandom, $urandom};
		for (int i = 0; i < `DSP_NDAC; i++) begin
			dac[i] = rand_dac();
		end
		mixbb1_sel = $urandom % 3;
		mixbb2_sel = $urandom % 3;
	end

	// watchdog and assertion monitor
	always @(posedge dspif) begin
		#2;
		cycles++;
		if (dut0.chk.errs != 0) begin
			abort_run("an assertion on the DUT outputs failed");
		end else if (cycles >= MAX_CYCLES) begin
			abort_run("timeout, the run did not finish in time");
		end
	end

	task automatic run_experiment(input int n);
		nshot = n;
		@(posedge dspif);
		#1 stb_start = 1'b1;
		@(posedge dspif);
		#1 stb_start = 1'b0;
		while (!last_shot_done) begin
			@(posedge dspif);
			#1;
		end
		repeat (2) @(posedge dspif);
		#1;
	endtask

	task automatic acc_bursts();
		// long burst, past the last address
		for (int c = 0; c < 70; c++) begin
			acc_valid = '1;
			for (int i = 0; i < `DSP_NACC; i++) begin
				acc_data[i] = {$urandom, $urandom};
			end
			@(posedge dspif);
			#1;
		end
		acc_valid = '0;
		resetacc = 1'b1;
		@(posedge dspif);
		#1 resetacc = 1'b0;
		// sparse random writes, rare clears
		for (int c = 0; c < 150; c++) begin
			acc_valid = $urandom;
			resetacc = ($urandom % 40) == 0;
			for (int i = 0; i < `DSP_NACC; i++) begin
				acc_data[i] = {$urandom, $urandom};
			end
			@(posedge dspif);
			#1;
		end
		acc_valid = '0;
		resetacc = 1'b0;
	endtask

	initial begin
		void'($urandom(35));
		dspif = 1'b0;
		reset = 1'b1;
		stb_start = 1'b0;
		nshot = '0;
		proc_done = '0;
		proc_idle = '0;
		adc = '0;
		mixbb1_sel = '0;
		mixbb2_sel = '0;
		acc_valid = '0;
		resetacc = 1'b0;
		for (int i = 0; i < `DSP_NDAC; i++) begin
			dac[i] = '0;
		end
		for (int i = 0; i < `DSP_NACC; i++) begin
			acc_data[i] = '0;
		end
		for (int i = 0; i < `DSP_NPROC; i++) begin
			done_wait[i] = 1;
			idle_wait[i] = 1;
		end
		repeat (3) @(posedge dspif);
		#1 reset = 1'b0;
		run_experiment(1);
		run_experiment(3);
		run_experiment(5);
		acc_bursts();
		repeat (3) @(posedge dspif);
		#3;
		if (dut0.chk.errs == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run("assertion failures were counted by the end of the run");
		end
	end

endmodule

// File: tests/dsp_top_sva.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module dsp_top_sva (
	input logic                      dspif,
	input logic                      reset,
	input logic                      stb_start,
	input logic                      stb_start_d,
	input dsp_ctrl_pkg::shot_count_t nshot,
	input dsp_ctrl_pkg::shot_count_t shot_count,
	input logic [`DSP_NPROC-1:0]     proc_done,
	input logic [`DSP_NPROC-1:0]     proc_reset,
	input logic                      last_shot_done,
	input logic                      procdone,
	input dsp_sample_pkg::adc_word_t adc,
	input dsp_sample_pkg::adc_word_t mixbb1,
	input dsp_sample_pkg::adc_word_t mixbb2,
	input dsp_sample_pkg::dac_word_t dac [0:`DSP_NDAC-1],
	input dsp_sample_pkg::bb_sel_t   mixbb1_sel,
	input dsp_sample_pkg::bb_sel_t   mixbb2_sel,
	input logic                      resetacc,
	input logic [`DSP_NACC-1:0]      acc_valid,
	input logic [`DSP_NACC-1:0]      we_accbuf,
	input logic [`DSP_NACC-1:0]      meas_bit,
	input logic [`DSP_NACC-1:0]      meas_valid,
	input dsp_sample_pkg::acc_data_t acc_data [0:`DSP_NACC-1],
	input dsp_sample_pkg::acc_data_t data_accbuf [0:`DSP_NACC-1],
	input dsp_sample_pkg::acc_addr_t addr_accbuf [0:`DSP_NACC-1]
);
	import dsp_sample_pkg::*;
	import dsp_ctrl_pkg::*;

	localparam int SW = `DSP_SAMPLE_W;

	// assertion failures seen so far
	int errs = 0;

	logic [1:0]           settle;
	logic                 prst_q;
	logic                 last_q;
	logic                 stb_q;
	logic                 fell_q;
	logic                 all_q1;
	logic                 all_q2;
	logic                 pd_q;
	logic                 racc_q;
	logic [`DSP_NACC-1:0] valid_q;
	logic [`DSP_NACC-1:0] we_q;
	logic                 fall;
	// falls of the core reset since the last start
	shot_count_t          falls;
	shot_count_t          nshot_l;
	adc_word_t            e1_q;
	adc_word_t            e1_qq;
	adc_word_t            e2_q;
	adc_word_t            e2_qq;
	acc_data_t            data_q [0:`DSP_NACC-1];
	acc_data_t            wdata_q [0:`DSP_NACC-1];
	acc_addr_t            addr_exp [0:`DSP_NACC-1];

	// baseband rule: keep samples 0, 4, 8 and 12 of a dac word
	function automatic adc_word_t pick(bb_sel_t sel, adc_word_t a, dac_word_t d0,
			dac_word_t d1);
		adc_word_t us0;
		adc_word_t us1;
		for (int j = 0; j < 4; j++) begin
			us0[SW*j +: SW] = d0[4*SW*j +: SW];
			us1[SW*j +: SW] = d1[4*SW*j +: SW];
		end
		if (sel == 2'd0) begin
			return a;
		end
		return (sel == 2'd1) ? us0 : us1;
	endfunction

	assign fall = prst_q && !proc_reset[0];

	// reference model registers
	always_ff @(posedge dspif) begin
		prst_q <= proc_reset[0];
		last_q <= last_shot_done;
		stb_q <= stb_start;
		fell_q <= fall;
		all_q1 <= &proc_done;
		all_q2 <= all_q1;
		pd_q <= procdone;
		racc_q <= resetacc;
		valid_q <= acc_valid;
		we_q <= we_accbuf;
		e1_q <= pick(mixbb1_sel, adc, dac[0], dac[1]);
		e1_qq <= e1_q;
		e2_q <= pick(mixbb2_sel, adc, dac[2], dac[3]);
		e2_qq <= e2_q;
		if (reset) begin
			settle <= '0;
		end else if (settle != 2'd2) begin
			settle <= settle + 1'b1;
		end
		if (stb_start) begin
			falls <= '0;
			nshot_l <= nshot;
		end else if (fall) begin
			falls <= falls + 1'b1;
		end
		for (int i = 0; i < `DSP_NACC; i++) begin
			data_q[i] <= acc_data[i];
			wdata_q[i] <= data_q[i];
			// clear wins, then advance unless parked at the last slot
			if (reset || racc_q) begin
				addr_exp[i] <= '0;
			end else if (valid_q[i] && (addr_exp[i] != '1)) begin
				addr_exp[i] <= addr_exp[i] + 1'b1;
			end
		end
	end

	// shot loop
	a_nshot: assert property (@(posedge dspif) disable iff (reset)
		last_shot_done |-> falls == nshot_l)
		else begin
			errs++;
			$error("Fail %0t shot starts got %0d exp %0d", $time, falls, nshot_l);
		end
	a_last_pulse: assert property (@(posedge dspif) disable iff (reset)
		!(last_shot_done && last_q))
		else begin
			errs++;
			$error("last_shot_done held longer than one cycle at %0t", $time);
		end
	// every core gets the same reset
	a_prst_all: assert property (@(posedge dspif) disable iff (reset)
		proc_reset == {`DSP_NPROC{proc_reset[0]}})
		else begin
			errs++;
			$error("Fail %0t proc_reset got %b exp %b", $time, proc_reset,
				{`DSP_NPROC{proc_reset[0]}});
		end
	a_shot_count: assert property (@(posedge dspif) disable iff (reset)
		(fall && falls != 0) |-> shot_count == falls - 1)
		else begin
			errs++;
			$error("Fail %0t shot_count got %0d exp %0d", $time, shot_count, falls - 1);
		end
	a_pd_rise: assert property (@(posedge dspif) disable iff (reset)
		(procdone && !pd_q) |-> all_q2)
		else begin
			errs++;
			$error("procdone rose before every core was done at %0t", $time);
		end
	// all cores done two cycles back sets the flag
	a_pd_set: assert property (@(posedge dspif) disable iff (reset)
		all_q2 |-> procdone)
		else begin
			errs++;
			$error("procdone stayed low after every core was done at %0t", $time);
		end
	a_pd_clear: assert property (@(posedge dspif) disable iff (reset)
		fell_q |-> !procdone)
		else begin
			errs++;
			$error("procdone still high after a new shot start at %0t", $time);
		end
	a_stb_d: assert property (@(posedge dspif) disable iff (reset)
		stb_start_d == stb_q)
		else begin
			errs++;
			$error("Fail %0t stb_start_d got %b exp %b", $time, stb_start_d, stb_q);
		end

	// baseband streams, two cycles behind their inputs
	a_bb1: assert property (@(posedge dspif) disable iff (reset)
		settle == 2'd2 |-> mixbb1 == e1_qq)
		else begin
			errs++;
			$error("Fail %0t mixbb1 got %h exp %h", $time, mixbb1, e1_qq);
		end
	a_bb2: assert property (@(posedge dspif) disable iff (reset)
		settle == 2'd2 |-> mixbb2 == e2_qq)
		else begin
			errs++;
			$error("Fail %0t mixbb2 got %h exp %h", $time, mixbb2, e2_qq);
		end

	// accumulation writes
	a_we: assert property (@(posedge dspif) disable iff (reset)
		settle == 2'd2 |-> we_accbuf == valid_q)
		else begin
			errs++;
			$error("Fail %0t we_accbuf got %b exp %b", $time, we_accbuf, valid_q);
		end
	a_mv: assert property (@(posedge dspif) disable iff (reset)
		settle == 2'd2 |-> meas_valid == we_q)
		else begin
			errs++;
			$error("Fail %0t meas_valid got %b exp %b", $time, meas_valid, we_q);
		end

	for (genvar i = 0; i < `DSP_NACC; i++) begin : g_chk
		a_data: assert property (@(posedge dspif) disable iff (reset)
			we_accbuf[i] |-> data_accbuf[i] == data_q[i])
			else begin
				errs++;
				$error("Fail %0t data_accbuf got %h exp %h", $time, data_accbuf[i], data_q[i]);
			end
		a_addr: assert property (@(posedge dspif) disable iff (reset)
			settle == 2'd2 |-> addr_accbuf[i] == addr_exp[i])
			else begin
				errs++;
				$error("Fail %0t addr_accbuf got %0d exp %0d", $time, addr_accbuf[i],
					addr_exp[i]);
			end
		// sign of the real half
		a_meas: assert property (@(posedge dspif) disable iff (reset)
			meas_valid[i] |-> meas_bit[i] == wdata_q[i][`DSP_ACC_W-1])
			else begin
				errs++;
				$error("Fail %0t meas_bit got %b exp %b", $time, meas_bit[i],
					wdata_q[i][`DSP_ACC_W-1]);
			end
	end

endmodule

bind dsp_top dsp_top_sva chk (.*);

// File: rtl/dsp_top.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module dsp_top (
	input  logic                      dspif,
	input  logic                      reset,
	// experiment control
	input  logic                      stb_start,
	input  dsp_ctrl_pkg::shot_count_t nshot,
	input  logic [`DSP_NPROC-1:0]     proc_done,
	input  logic [`DSP_NPROC-1:0]     proc_idle,
	// converter data and baseband selects
	input  dsp_sample_pkg::adc_word_t adc,
	input  dsp_sample_pkg::dac_word_t dac [0:`DSP_NDAC-1],
	input  dsp_sample_pkg::bb_sel_t   mixbb1_sel,
	input  dsp_sample_pkg::bb_sel_t   mixbb2_sel,
	// readout results from the accumulators
	input  logic [`DSP_NACC-1:0]      acc_valid,
	input  dsp_sample_pkg::acc_data_t acc_data [0:`DSP_NACC-1],
	input  logic                      resetacc,
	output logic [`DSP_NPROC-1:0]     proc_reset,
	output dsp_ctrl_pkg::shot_count_t shot_count,
	output logic                      last_shot_done,
	output logic                      procdone,
	output dsp_sample_pkg::adc_word_t mixbb1,
	output dsp_sample_pkg::adc_word_t mixbb2,
	output logic [`DSP_NACC-1:0]      we_accbuf,
	output dsp_sample_pkg::acc_addr_t addr_accbuf [0:`DSP_NACC-1],
	output dsp_sample_pkg::acc_data_t data_accbuf [0:`DSP_NACC-1],
	output logic [`DSP_NACC-1:0]      meas_bit,
	output logic [`DSP_NACC-1:0]      meas_valid,
	output logic                      stb_start_d
);

	// shot loop and core reset
	shot_sequencer u_seq (
		.dspif          (dspif),
		.reset          (reset),
		.stb_start      (stb_start),
		.nshot          (nshot),
		.proc_done      (proc_done),
		.proc_idle      (proc_idle),
		.proc_reset     (proc_reset),
		.shot_count     (shot_count),
		.last_shot_done (last_shot_done),
		.procdone       (procdone)
	);

	// readout baseband streams
	bb_select u_bb (
		.dspif      (dspif),
		.reset      (reset),
		.adc        (adc),
		.dac        (dac),
		.mixbb1_sel (mixbb1_sel),
		.mixbb2_sel (mixbb2_sel),
		.mixbb1     (mixbb1),
		.mixbb2     (mixbb2)
	);

	// accumulation buffer writes and measurement bits
	acc_buf_writer u_acc (
		.dspif       (dspif),
		.reset       (reset),
		.resetacc    (resetacc),
		.acc_valid   (acc_valid),
		.acc_data    (acc_data),
		.we_accbuf   (we_accbuf),
		.addr_accbuf (addr_accbuf),
		.data_accbuf (data_accbuf),
		.meas_bit    (meas_bit),
		.meas_valid  (meas_valid)
	);

	// start strobe for the external capture buffers
	always_ff @(posedge dspif) begin
		if (reset) begin
			stb_start_d <= 1'b0;
		end else begin
			stb_start_d <= stb_start;
		end
	end

endmodule

// File: rtl/acc_buf_writer.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module acc_buf_writer (
	input  logic                      dspif,
	input  logic                      reset,
	input  logic                      resetacc,
	input  logic [`DSP_NACC-1:0]      acc_valid,
	input  dsp_sample_pkg::acc_data_t acc_data [0:`DSP_NACC-1],
	output logic [`DSP_NACC-1:0]      we_accbuf,
	output dsp_sample_pkg::acc_addr_t addr_accbuf [0:`DSP_NACC-1],
	output dsp_sample_pkg::acc_data_t data_accbuf [0:`DSP_NACC-1],
	output logic [`DSP_NACC-1:0]      meas_bit,
	output logic [`DSP_NACC-1:0]      meas_valid
);
	import dsp_sample_pkg::*;

	// pointer clear, registered once and shared by all channels
	logic resetacc_r;

	always_ff @(posedge dspif) begin
		if (reset) begin
			resetacc_r <= 1'b0;
		end else begin
			resetacc_r <= resetacc;
		end
	end

	for (genvar i = 0; i < `DSP_NACC; i++) begin : g_chan
		logic      we_r;
		acc_addr_t addr_r;
		acc_data_t data_r;
		logic      locklast;
		logic      mv_r;
		logic      mb_r;

		// last location reached, stop advancing
		assign locklast = &addr_r;

		always_ff @(posedge dspif) begin
			data_r <= acc_data[i];
			// threshold on the real axis, sign of x
			mb_r <= data_r[`DSP_ACC_W-1];
			if (reset) begin
				we_r <= 1'b0;
				mv_r <= 1'b0;
				addr_r <= '0;
			end else begin
				we_r <= acc_valid[i];
				mv_r <= we_r;
				if (resetacc_r) begin
					addr_r <= '0;
				end else if (we_r && !locklast) begin
					addr_r <= addr_r + 1'b1;
				end
			end
		end

		assign we_accbuf[i] = we_r;
		assign addr_accbuf[i] = addr_r;
		assign data_accbuf[i] = data_r;
		assign meas_valid[i] = mv_r;
		assign meas_bit[i] = mb_r;
	end

endmodule

// File: rtl/bb_select.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module bb_select (
	input  logic                      dspif,
	input  logic                      reset,
	input  dsp_sample_pkg::adc_word_t adc,
	input  dsp_sample_pkg::dac_word_t dac [0:`DSP_NDAC-1],
	input  dsp_sample_pkg::bb_sel_t   mixbb1_sel,
	input  dsp_sample_pkg::bb_sel_t   mixbb2_sel,
	output dsp_sample_pkg::adc_word_t mixbb1,
	output dsp_sample_pkg::adc_word_t mixbb2
);
	import dsp_sample_pkg::*;

	localparam int SW = `DSP_SAMPLE_W;
	// samples kept per undersampled word
	localparam int NUS = `DSP_ADC_W / SW;
	// dac sample stride, every fourth sample
	localparam int US_STEP = (`DSP_DAC_W / SW) / NUS;

	adc_word_t adc_r;
	adc_word_t dac_us [0:`DSP_NDAC-1];
	// select codes delayed to match the data stage
	bb_sel_t   sel1_r;
	bb_sel_t   sel2_r;

	// first stage, adc and undersampled dac words
	always_ff @(posedge dspif) begin
		adc_r <= adc;
		for (int i = 0; i < `DSP_NDAC; i++) begin
			for (int j = 0; j < NUS; j++) begin
				dac_us[i][j*SW +: SW] <= dac[i][j*US_STEP*SW +: SW];
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			sel1_r <= '0;
			sel2_r <= '0;
		end else begin
			sel1_r <= mixbb1_sel;
			sel2_r <= mixbb2_sel;
		end
	end

	// second stage, baseband muxes
	// code 3 keeps the last selection
	always_ff @(posedge dspif) begin
		if (reset) begin
			mixbb1 <= '0;
			mixbb2 <= '0;
		end else begin
			case (sel1_r)
				2'd0: mixbb1 <= adc_r;
				2'd1: mixbb1 <= dac_us[0];
				2'd2: mixbb1 <= dac_us[1];
				default: mixbb1 <= mixbb1;
			endcase
			// second stream looks at the upper dac pair
			case (sel2_r)
				2'd0: mixbb2 <= adc_r;
				2'd1: mixbb2 <= dac_us[2];
				2'd2: mixbb2 <= dac_us[3];
				default: mixbb2 <= mixbb2;
			endcase
		end
	end

endmodule

// File: rtl/shot_sequencer.sv
`timescale 1ns/1ps
`include "dsp_defines.svh"

module shot_sequencer (
	input  logic                      dspif,
	input  logic                      reset,
	input  logic                      stb_start,
	input  dsp_ctrl_pkg::shot_count_t nshot,
	input  logic [`DSP_NPROC-1:0]     proc_done,
	input  logic [`DSP_NPROC-1:0]     proc_idle,
	output logic [`DSP_NPROC-1:0]     proc_reset,
	output dsp_ctrl_pkg::shot_count_t shot_count,
	output logic                      last_shot_done,
	output logic                      procdone
);
	import dsp_ctrl_pkg::*;

	seq_state_t  state;
	seq_state_t  nextstate;

	// shot total, frozen for the whole experiment
	shot_count_t nshot_r;
	// running shot index and its increment
	shot_count_t shotcnt;
	shot_count_t nextshotcnt;
	// repeat decision, one cycle behind nextshotcnt
	logic        shotadd;

	// registered core reductions
	logic        procdone_r;
	logic        nobusy_r;

	// shared core reset before fan-out
	logic        core_reset;
	// high for the START cycle only
	logic        procstart;

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= nextstate;
		end
	end

	always_comb begin
		nextstate = IDLE;
		case (state)
			IDLE: begin
				nextstate = stb_start ? START : IDLE;
			end
			START: begin
				nextstate = PROCRUN;
			end
			PROCRUN: begin
				// wait for every core to report done
				nextstate = procdone_r ? ELEMBUSY : PROCRUN;
			end
			ELEMBUSY: begin
				// element outputs still draining
				nextstate = nobusy_r ? MORESHOT : ELEMBUSY;
			end
			MORESHOT: begin
				nextstate = shotadd ? SHOTADD : DONE;
			end
			SHOTADD: begin
				nextstate = START;
			end
			DONE: begin
				nextstate = IDLE;
			end
			default: begin
				nextstate = IDLE;
			end
		endcase
	end

	// nshot only sampled while waiting for a start
	always_ff @(posedge dspif) begin
		if (reset) begin
			nshot_r <= '0;
		end else if (state == IDLE) begin
			nshot_r <= nshot;
		end
	end

	// reductions and count compare, precomputed ahead of MORESHOT
	always_ff @(posedge dspif) begin
		if (reset) begin
			procdone_r <= 1'b0;
			nobusy_r <= 1'b0;
			nextshotcnt <= '0;
			shotadd <= 1'b0;
		end else begin
			procdone_r <= &proc_done;
			nobusy_r <= &proc_idle;
			nextshotcnt <= shotcnt + 1'b1;
			// nshot of zero repeats forever
			shotadd <= (nextshotcnt != nshot_r) || (nshot_r == '0);
		end
	end

	// outputs decoded from nextstate, so they line up with state
	always_ff @(posedge dspif) begin
		if (reset) begin
			core_reset <= 1'b1;
			procstart <= 1'b0;
			last_shot_done <= 1'b0;
			shotcnt <= '0;
			shot_count <= '0;
		end else begin
			// cores run only in START and PROCRUN
			core_reset <= !((nextstate == START) || (nextstate == PROCRUN));
			procstart <= (nextstate == START);
			last_shot_done <= (nextstate == DONE);
			if ((nextstate == IDLE) || (nextstate == DONE)) begin
				shotcnt <= '0;
			end else if (nextstate == SHOTADD) begin
				shotcnt <= nextshotcnt;
				// report the shot just finished
				shot_count <= shotcnt;
			end
		end
	end

	// one extra stage before the per-core reset
	always_ff @(posedge dspif) begin
		if (reset) begin
			proc_reset <= '1;
		end else begin
			proc_reset <= {`DSP_NPROC{core_reset}};
		end
	end

	// sticky done flag, cleared when the next shot starts
	always_ff @(posedge dspif) begin
		if (reset) begin
			procdone <= 1'b0;
		end else if (procdone_r) begin
			procdone <= 1'b1;
		end else if (procstart) begin
			procdone <= 1'b0;
		end
	end

endmodule

// File: rtl/dsp_ctrl_pkg.sv
`include "dsp_defines.svh"

package dsp_ctrl_pkg;

	// shot loop states
	// gray-like walk along the main path, one bit flips per step
	typedef enum logic [3:0] {
		IDLE     = 4'b0000,
		START    = 4'b0001,
		PROCRUN  = 4'b0011,
		ELEMBUSY = 4'b0010,
		MORESHOT = 4'b0110,
		SHOTADD  = 4'b0111,
		DONE     = 4'b0101
	} seq_state_t;

	// shot number and shot total
	typedef logic [`DSP_SHOT_W-1:0] shot_count_t;

endpackage

// File: rtl/dsp_sample_pkg.sv
`include "dsp_defines.svh"

package dsp_sample_pkg;

	// raw dac word from the drive path
	typedef logic [`DSP_DAC_W-1:0] dac_word_t;

	// adc word, also the shape of an undersampled dac word
	typedef logic [`DSP_ADC_W-1:0] adc_word_t;

	// one accumulated readout result
	typedef logic [`DSP_ACC_W-1:0] acc_data_t;

	// accumulation buffer write address
	typedef logic [`DSP_ACCADDR_W-1:0] acc_addr_t;

	// baseband mux select
	typedef logic [`DSP_BBSEL_W-1:0] bb_sel_t;

endpackage

// File: rtl/dsp_defines.svh
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// core and channel counts
`define DSP_NPROC 4
`define DSP_NDAC 4
`define DSP_NACC 4

// one adc or dac sample
`define DSP_SAMPLE_W 16

// dac word carries 16 samples per clock
`define DSP_DAC_W 256
// adc word carries 4 samples per clock
`define DSP_ADC_W 64

// accumulation result, x in the high half, y in the low half
`define DSP_ACC_W 64
// depth of each accumulation buffer is 2**6
`define DSP_ACCADDR_W 6

// shot counter and baseband select code
`define DSP_SHOT_W 32
`define DSP_BBSEL_W 2

`endif
